/* src/icache_pkg.sv */
//////////////////////////////////////////////////
// shared geometry and types of the instruction
// cache, imported by every RTL block
//////////////////////////////////////////////////

`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////
  // cache geometry
  localparam int ADR_W      = 32;
  localparam int WORD_W     = 32;
  localparam int WAYS       = 2;
  localparam int SETS       = 8;
  localparam int LINE_WORDS = 4;
  localparam int IDX_W      = 3;
  localparam int OFS_W      = 2;
  // 32 - idx - word offset - byte offset
  localparam int TAG_W      = 25;

  //////////////////////////////////////////////////
  // address views

  // fields of a fetch address as the cache sees it
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic [OFS_W-1:0] ofs;
    logic [1:0]       byt;
  } cache_adr_t;

  // same word, raw for the bus, split for the arrays
  typedef union packed {
    logic [ADR_W-1:0] raw;
    cache_adr_t       f;
  } fetch_adr_u;

  // one cache line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  //////////////////////////////////////////////////
  // memory port and fill path

  // request level, adr held until ack or err
  typedef struct packed {
    logic             req;
    logic [ADR_W-1:0] adr;
  } mem_req_t;

  // single-cycle response
  typedef struct packed {
    logic              ack;
    logic              err;
    logic [WORD_W-1:0] rdata;
  } mem_rsp_t;

  // finished line from refill engine into the store
  typedef struct packed {
    logic             we;
    logic [IDX_W-1:0] idx;
    logic             way;
    logic [TAG_W-1:0] tag;
    line_t            line;
  } fill_t;

endpackage

`default_nettype wire

/* src/icache_ctrl.sv */
//////////////////////////////////////////////////
// fetch-side control FSM of the instruction cache
// decides hit, refill, uncached fetch, invalidate
// and drives stall and parcel back to the core
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // core side
  input  wire logic                   fetch_req_i,
  input  icache_pkg::fetch_adr_u      fetch_adr_i,
  input  wire logic                   cacheable_i,
  input  wire logic                   flush_i,
  input  wire logic                   invalidate_i,
  output logic                        stall_o,
  output logic [icache_pkg::WORD_W-1:0] parcel_o,
  output logic                        parcel_valid_o,
  output logic                        parcel_error_o,
  output logic                        parcel_misaligned_o,
  // store
  input  wire logic                   hit_i,
  input  wire logic [icache_pkg::WORD_W-1:0] hit_word_i,
  input  wire logic                   victim_way_i,
  output icache_pkg::fetch_adr_u      lookup_adr_o,
  output logic                        inv_all_o,
  // refill engine
  output logic                        refill_start_o,
  output icache_pkg::fetch_adr_u      miss_adr_o,
  output logic                        fill_way_o,
  input  wire logic                   refill_done_i,
  input  wire logic                   refill_err_i,
  // uncached bus path
  output icache_pkg::mem_req_t        unc_req_o,
  input  icache_pkg::mem_rsp_t        unc_rsp_i
);

  import icache_pkg::*;

  typedef enum logic [2:0] {
    ARMED,
    INVALIDATE,
    UNCACHED,
    REFILL,
    RECOVER0,
    RECOVER1
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic       inv_hold_q;
  logic       inv_pend;
  logic       misaligned;
  logic       valid_req;
  logic       armed;
  logic       cache_ack;
  logic       start_q;
  logic       rf_err_q;
  logic       way_q;
  fetch_adr_u miss_adr_q;

  //////////////////////////////////////////////////
  // request qualification

  assign misaligned = (fetch_adr_i.f.byt != 2'b00);
  assign valid_req  = fetch_req_i & ~misaligned & ~flush_i;
  assign inv_pend   = invalidate_i | inv_hold_q;
  assign armed      = (state_q == ARMED);

  // hit served straight from the arrays, no wait
  assign cache_ack = armed & valid_req & cacheable_i & hit_i & ~inv_pend;

  // keep invalidate until INVALIDATE state runs
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inv_hold_q <= 1'b0;
    else
      inv_hold_q <= invalidate_i | (inv_hold_q & ~inv_all_o);
  end

  //////////////////////////////////////////////////
  // state machine

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ARMED:
      begin
        if (inv_pend)
          state_d = INVALIDATE;
        else if (valid_req && !cacheable_i)
          state_d = UNCACHED;
        else if (valid_req && !hit_i)
          state_d = REFILL;
      end
      INVALIDATE: state_d = RECOVER0;
      // request is accepted, so flush no longer drops it
      UNCACHED:
      begin
        if (unc_rsp_i.ack || unc_rsp_i.err)
          state_d = ARMED;
      end
      REFILL:
      begin
        if (refill_done_i || refill_err_i)
          state_d = RECOVER0;
      end
      // arrays settle after write, then re-lookup
      RECOVER0: state_d = RECOVER1;
      RECOVER1: state_d = ARMED;
      default:  state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q  <= ARMED;
      start_q  <= 1'b0;
      rf_err_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      start_q  <= armed & (state_d == REFILL);
      rf_err_q <= refill_err_i;
    end
  end

  // miss context, captured when leaving ARMED
  always_ff @(posedge clk_i)
  begin
    if (armed && state_d == REFILL)
    begin
      miss_adr_q <= fetch_adr_i;
      way_q      <= victim_way_i;
    end
  end

  assign refill_start_o = start_q;
  assign miss_adr_o     = miss_adr_q;
  assign fill_way_o     = way_q;
  assign lookup_adr_o   = fetch_adr_i;
  assign inv_all_o      = (state_q == INVALIDATE);

  //////////////////////////////////////////////////
  // uncached bus request

  assign unc_req_o.req = (state_q == UNCACHED) |
                         (armed & valid_req & ~cacheable_i & ~inv_pend);
  // bus is word addressed
  assign unc_req_o.adr = {fetch_adr_i.raw[ADR_W-1:2], 2'b00};

  //////////////////////////////////////////////////
  // core outputs

  always_comb
  begin
    unique case (state_q)
      ARMED:    stall_o = inv_pend | (valid_req & ~(cacheable_i & hit_i));
      UNCACHED: stall_o = ~(unc_rsp_i.ack | unc_rsp_i.err);
      default:  stall_o = 1'b1;
    endcase
  end

  assign parcel_o = (state_q == UNCACHED) ? unc_rsp_i.rdata : hit_word_i;

  assign parcel_valid_o = cache_ack | ((state_q == UNCACHED) & unc_rsp_i.ack);

  // refill error reported one cycle late, uncached error at once
  assign parcel_error_o = rf_err_q | ((state_q == UNCACHED) & unc_rsp_i.err);

  assign parcel_misaligned_o = armed & fetch_req_i & misaligned & ~inv_pend;

  //////////////////////////////////////////////////
  // checks

  // uncached reply only lands while UNCACHED waits for it
  a_unc_rsp_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (unc_rsp_i.ack || unc_rsp_i.err) |-> state_q == UNCACHED);

  // refill engine only answers while the FSM waits in REFILL
  a_refill_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (refill_done_i || refill_err_i) |-> state_q == REFILL);

endmodule

`default_nettype wire

/* src/icache_store.sv */
//////////////////////////////////////////////////
// tag, valid, lru and data arrays of the cache
// lookup is combinational, writes come from fill
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_store (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  icache_pkg::fetch_adr_u             lookup_adr_i,
  output logic                               hit_o,
  output logic [icache_pkg::WORD_W-1:0]      hit_word_o,
  output logic                               victim_way_o,
  input  icache_pkg::fill_t                  fill_i,
  input  wire logic                          inv_all_i
);

  import icache_pkg::*;

  // arrays, no reset on payload
  logic [TAG_W-1:0]            tag_q  [SETS][WAYS];
  line_t                       data_q [SETS][WAYS];
  // control bits
  logic [SETS-1:0][WAYS-1:0]   valid_q;
  // per set, way to replace next
  logic [SETS-1:0]             lru_q;

  logic [WAYS-1:0] way_hit;
  logic            hit_way;
  line_t           hit_line;

  //////////////////////////////////////////////////
  // lookup

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      way_hit[w] = valid_q[lookup_adr_i.f.idx][w] &
                   (tag_q[lookup_adr_i.f.idx][w] == lookup_adr_i.f.tag);
    end
  end

  assign hit_o = |way_hit;
  // two ways, so way 1 hit decides
  assign hit_way  = way_hit[1];
  assign hit_line = data_q[lookup_adr_i.f.idx][hit_way];
  // word select by offset
  assign hit_word_o   = hit_line[lookup_adr_i.f.ofs];
  assign victim_way_o = lru_q[lookup_adr_i.f.idx];

  //////////////////////////////////////////////////
  // line write

  always_ff @(posedge clk_i)
  begin
    if (fill_i.we)
    begin
      tag_q[fill_i.idx][fill_i.way]  <= fill_i.tag;
      data_q[fill_i.idx][fill_i.way] <= fill_i.line;
    end
  end

  // invalidate-all wins over a fill
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else if (inv_all_i)
      valid_q <= '0;
    else if (fill_i.we)
      valid_q[fill_i.idx][fill_i.way] <= 1'b1;
  end

  //////////////////////////////////////////////////
  // lru, fill first then hit

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lru_q <= '0;
    else
    begin
      for (int s = 0; s < SETS; s++)
      begin
        if (fill_i.we && fill_i.idx == IDX_W'(s))
          lru_q[s] <= ~fill_i.way;
        else if (hit_o && lookup_adr_i.f.idx == IDX_W'(s))
          lru_q[s] <= ~hit_way;
      end
    end
  end

  // victim choice keeps a tag in one way only
  a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(&way_hit));

endmodule

`default_nettype wire

/* src/line_refill.sv */
//////////////////////////////////////////////////
// refill engine: reads the four words of a missed
// line and hands the whole line to the store
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module line_refill (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  icache_pkg::fetch_adr_u  miss_adr_i,
  input  wire logic               way_i,
  output icache_pkg::mem_req_t    rf_req_o,
  input  icache_pkg::mem_rsp_t    rf_rsp_i,
  output icache_pkg::fill_t       fill_o,
  output logic                    done_o,
  output logic                    err_o
);

  import icache_pkg::*;

  logic             busy_q;
  logic [OFS_W-1:0] cnt_q;
  logic             last;
  fetch_adr_u       base_q;
  logic             way_q;
  line_t            buf_q;
  line_t            line_now;

  assign last = (cnt_q == OFS_W'(LINE_WORDS - 1));

  //////////////////////////////////////////////////
  // bus side, walk offsets 0..3 from the line base

  assign rf_req_o.req = busy_q;
  assign rf_req_o.adr = {base_q.f.tag, base_q.f.idx, cnt_q, 2'b00};

  // incoming word merged into the buffer
  always_comb
  begin
    line_now         = buf_q;
    line_now[cnt_q]  = rf_rsp_i.rdata;
  end

  assign done_o = busy_q & rf_rsp_i.ack & last;
  assign err_o  = busy_q & rf_rsp_i.err;

  //////////////////////////////////////////////////
  // fill, written on the cycle of the last ack
  assign fill_o.we   = done_o;
  assign fill_o.idx  = base_q.f.idx;
  assign fill_o.way  = way_q;
  assign fill_o.tag  = base_q.f.tag;
  assign fill_o.line = line_now;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end
    else if (start_i)
    begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end
    else if (busy_q)
    begin
      // err drops the line, nothing written
      if (rf_rsp_i.err)
        busy_q <= 1'b0;
      else if (rf_rsp_i.ack)
      begin
        cnt_q <= cnt_q + 1'b1;
        if (last)
          busy_q <= 1'b0;
      end
    end
  end

  // line context and gathered words
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      base_q <= miss_adr_i;
      way_q  <= way_i;
    end
    if (busy_q && rf_rsp_i.ack)
      buf_q <= line_now;
  end

  // controller waits for done or err before a new miss
  a_no_restart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q);

endmodule

`default_nettype wire

/* src/fetch_bus_arb.sv */
//////////////////////////////////////////////////
// fixed-priority arbiter for the one memory port
// refill engine first, then the uncached path
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_bus_arb (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  icache_pkg::mem_req_t  rf_req_i,
  input  icache_pkg::mem_req_t  unc_req_i,
  output icache_pkg::mem_rsp_t  rf_rsp_o,
  output icache_pkg::mem_rsp_t  unc_rsp_o,
  output icache_pkg::mem_req_t  mem_req_o,
  input  icache_pkg::mem_rsp_t  mem_rsp_i
);

  import icache_pkg::*;

  logic busy_q;
  logic grant_rf_q;
  logic sel_rf;
  logic done;

  assign done = mem_rsp_i.ack | mem_rsp_i.err;

  // locked owner, else refill wins
  assign sel_rf = busy_q ? grant_rf_q : rf_req_i.req;

  assign mem_req_o = sel_rf ? rf_req_i : unc_req_i;

  // response only to the owner of an open request
  assign rf_rsp_o  = (mem_req_o.req &&  sel_rf) ? mem_rsp_i : '0;
  assign unc_rsp_o = (mem_req_o.req && !sel_rf) ? mem_rsp_i : '0;

  // lock from req until ack or err
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q     <= 1'b0;
      grant_rf_q <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (mem_req_o.req && !done)
      begin
        busy_q     <= 1'b1;
        grant_rf_q <= sel_rf;
      end
    end
    else if (done)
      busy_q <= 1'b0;
  end

  // owner keeps req and adr on the port until the transfer closes
  a_grant_locked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q && !done) |=> $stable(mem_req_o));

endmodule

`default_nettype wire

/* src/icache_top.sv */
//////////////////////////////////////////////////
// instruction cache top, connects control FSM,
// arrays, refill engine and bus arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     fetch_req_i,
  input  icache_pkg::fetch_adr_u        fetch_adr_i,
  input  wire logic                     cacheable_i,
  input  wire logic                     flush_i,
  input  wire logic                     invalidate_i,
  output logic                          stall_o,
  output logic [icache_pkg::WORD_W-1:0] parcel_o,
  output logic                          parcel_valid_o,
  output logic                          parcel_error_o,
  output logic                          parcel_misaligned_o,
  output icache_pkg::mem_req_t          mem_req_o,
  input  icache_pkg::mem_rsp_t          mem_rsp_i
);

  import icache_pkg::*;

  // controller <-> store
  logic              hit;
  logic [WORD_W-1:0] hit_word;
  logic              victim_way;
  fetch_adr_u        lookup_adr;
  logic              inv_all;
  // controller <-> refill engine
  logic              refill_start;
  fetch_adr_u        miss_adr;
  logic              fill_way;
  logic              refill_done;
  logic              refill_err;
  fill_t             fill;
  // bus masters
  mem_req_t          unc_req;
  mem_req_t          rf_req;
  mem_rsp_t          unc_rsp;
  mem_rsp_t          rf_rsp;

  icache_ctrl u_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_req_i         (fetch_req_i),
    .fetch_adr_i         (fetch_adr_i),
    .cacheable_i         (cacheable_i),
    .flush_i             (flush_i),
    .invalidate_i        (invalidate_i),
    .stall_o             (stall_o),
    .parcel_o            (parcel_o),
    .parcel_valid_o      (parcel_valid_o),
    .parcel_error_o      (parcel_error_o),
    .parcel_misaligned_o (parcel_misaligned_o),
    .hit_i               (hit),
    .hit_word_i          (hit_word),
    .victim_way_i        (victim_way),
    .lookup_adr_o        (lookup_adr),
    .inv_all_o           (inv_all),
    .refill_start_o      (refill_start),
    .miss_adr_o          (miss_adr),
    .fill_way_o          (fill_way),
    .refill_done_i       (refill_done),
    .refill_err_i        (refill_err),
    .unc_req_o           (unc_req),
    .unc_rsp_i           (unc_rsp)
  );

  icache_store u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_adr_i (lookup_adr),
    .hit_o        (hit),
    .hit_word_o   (hit_word),
    .victim_way_o (victim_way),
    .fill_i       (fill),
    .inv_all_i    (inv_all)
  );

  line_refill u_refill (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (refill_start),
    .miss_adr_i (miss_adr),
    .way_i      (fill_way),
    .rf_req_o   (rf_req),
    .rf_rsp_i   (rf_rsp),
    .fill_o     (fill),
    .done_o     (refill_done),
    .err_o      (refill_err)
  );

  fetch_bus_arb u_arb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rf_req_i  (rf_req),
    .unc_req_i (unc_req),
    .rf_rsp_o  (rf_rsp),
    .unc_rsp_o (unc_rsp),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
//////////////////////////////////////////////////
// memory responder for the cache testbench
// data from the address, random latency 1 to 4,
// err for the region at 0x0000_f000 and above
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  icache_pkg::mem_req_t mem_req_i,
  output icache_pkg::mem_rsp_t mem_rsp_o
);

  import icache_pkg::*;

  localparam logic [ADR_W-1:0] ERR_BASE = 32'h0000_f000;
  localparam int               RSP_DLY  = 2;

  integer           seed;
  int               wait_cnt;
  logic             busy;
  // response just given, req still shows the old adr
  logic             answered;
  logic [ADR_W-1:0] adr_q;

  // word for an address, err above the error base
  function automatic mem_rsp_t respond(input logic [ADR_W-1:0] adr);
    mem_rsp_t rsp;
    rsp.ack   = (adr < ERR_BASE);
    rsp.err   = (adr >= ERR_BASE);
    rsp.rdata = rsp.ack ? (adr ^ 32'h5a5a_5a5a) : '0;
    return rsp;
  endfunction

  initial
  begin
    seed      = 32'hee0e_e0ce;
    busy      = 1'b0;
    answered  = 1'b0;
    wait_cnt  = 0;
    mem_rsp_o = '0;
  end

  always @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      busy      = 1'b0;
      answered  = 1'b0;
      mem_rsp_o <= #RSP_DLY '0;
    end
    else if (busy && wait_cnt == 0)
    begin
      busy      = 1'b0;
      answered  = 1'b1;
      mem_rsp_o <= #RSP_DLY respond(adr_q);
    end
    else
    begin
      if (busy)
        wait_cnt = wait_cnt - 1;
      else if (mem_req_i.req && !answered)
      begin
        // new transfer, extra wait 0..3
        busy     = 1'b1;
        adr_q    = mem_req_i.adr;
        wait_cnt = $unsigned($random(seed)) % 4;
      end
      answered  = 1'b0;
      mem_rsp_o <= #RSP_DLY '0;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_icache.sv */
//////////////////////////////////////////////////
// testbench for the instruction cache: random
// fetch stream checked against a mirror of tags,
// valid and lru bits, plus bus address checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam int               CLK_PERIOD  = 40;
  localparam int               DRV_DLY     = 2;
  localparam int               RST_CYCLES  = 8;
  localparam int               N_FETCH     = 400;
  localparam int               FETCH_LIMIT = 40;
  localparam logic [ADR_W-1:0] ERR_BASE    = 32'h0000_f000;
  localparam longint           WATCHDOG_NS =
    longint'(N_FETCH) * FETCH_LIMIT * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;

  logic              clk;
  logic              rst_n;
  logic              fetch_req;
  fetch_adr_u        fetch_adr;
  logic              cacheable;
  logic              flush;
  logic              invalidate;
  logic              stall;
  logic [WORD_W-1:0] parcel;
  logic              parcel_valid;
  logic              parcel_error;
  logic              parcel_misaligned;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;

  integer seed;
  int     parcel_errs;
  int     bus_errs;
  int     ctrl_errs;

  // mirror of the cache arrays
  logic             m_valid [SETS][WAYS];
  logic [TAG_W-1:0] m_tag   [SETS][WAYS];
  logic             m_lru   [SETS];

  icache_top dut0 (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .fetch_req_i         (fetch_req),
    .fetch_adr_i         (fetch_adr),
    .cacheable_i         (cacheable),
    .flush_i             (flush),
    .invalidate_i        (invalidate),
    .stall_o             (stall),
    .parcel_o            (parcel),
    .parcel_valid_o      (parcel_valid),
    .parcel_error_o      (parcel_error),
    .parcel_misaligned_o (parcel_misaligned),
    .mem_req_o           (mem_req),
    .mem_rsp_i           (mem_rsp)
  );

  tb_mem_model mem0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model

  // memory rule, word-aligned address xor pattern
  function automatic logic [WORD_W-1:0] mem_word(input logic [ADR_W-1:0] adr);
    return {adr[ADR_W-1:2], 2'b00} ^ 32'h5a5a_5a5a;
  endfunction

  task automatic lookup(input logic [ADR_W-1:0] adr, output logic hit, output logic way);
    cache_adr_t a;
    a   = adr;
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (m_valid[a.idx][w] && m_tag[a.idx][w] == a.tag)
      begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
  endtask

  // arrays see every driven address, so a hit moves lru
  task automatic touch(input logic [ADR_W-1:0] adr);
    cache_adr_t a;
    logic       hit;
    logic       way;
    a = adr;
    lookup(adr, hit, way);
    if (hit)
      m_lru[a.idx] = ~way;
  endtask

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_parcel(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
    if (got !== exp)
    begin
      parcel_errs++;
      $display("Fail parcel_o: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_bus_adr(input mem_req_t got, input mem_req_t exp);
    if (got !== exp)
    begin
      bus_errs++;
      $display("Fail mem_req_o: got %h, expected %h", got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus

  task automatic run_fetch(input logic [ADR_W-1:0] adr, input logic cach);
    cache_adr_t a;
    mem_req_t   exp_q[$];
    mem_req_t   got_q[$];
    logic       hit;
    logic       way;
    logic       mis;
    logic       err_rgn;
    logic       req_seen;
    // pulses as {valid, error, misaligned}
    logic [2:0] exp_end;
    logic [2:0] got_end;
    int         cyc;
    a       = adr;
    mis     = (a.byt != 2'b00);
    err_rgn = (adr >= ERR_BASE);
    touch(adr);
    lookup(adr, hit, way);
    // bus words this fetch should need
    if (!mis && !cach)
      exp_q.push_back({1'b1, adr[ADR_W-1:2], 2'b00});
    else if (!mis && !hit)
    begin
      // error region aborts on the first word
      for (int i = 0; i < LINE_WORDS; i++)
        if (i == 0 || !err_rgn)
          exp_q.push_back({1'b1, a.tag, a.idx, 2'(i), 2'b00});
    end
    exp_end = mis ? 3'b001 : (err_rgn ? 3'b010 : 3'b100);

    @(posedge clk);
    #DRV_DLY;
    fetch_req     = 1'b1;
    fetch_adr.raw = adr;
    cacheable     = cach;
    flush         = 1'b0;
    invalidate    = 1'b0;
    got_end       = 3'b000;
    req_seen      = 1'b0;
    cyc           = 0;
    // hold the request until an ending pulse
    while (got_end == 3'b000 && cyc < FETCH_LIMIT)
    begin
      @(negedge clk);
      cyc++;
      req_seen = req_seen | mem_req.req;
      if (mem_rsp.ack || mem_rsp.err)
        got_q.push_back(mem_req);
      got_end = {parcel_valid, parcel_error, parcel_misaligned};
    end

    if (got_end == 3'b000)
    begin
      ctrl_errs++;
      $display("fetch at %h did not finish within %0d cycles", adr, FETCH_LIMIT);
    end
    else if (got_end != exp_end)
    begin
      ctrl_errs++;
      $display("fetch at %h ended with pulses %b, expected %b", adr, got_end, exp_end);
    end
    else if (exp_end == 3'b100)
      check_parcel(parcel, mem_word(adr));

    if (exp_q.size() == 0 && req_seen)
    begin
      bus_errs++;
      $display("fetch at %h used the bus although none was expected", adr);
    end
    else if (got_q.size() != exp_q.size())
    begin
      bus_errs++;
      $display("fetch at %h made %0d bus transfers, expected %0d", adr,
               got_q.size(), exp_q.size());
    end
    else
    begin
      foreach (got_q[i])
        check_bus_adr(got_q[i], exp_q[i]);
    end

    // refill of a good cacheable miss lands in the lru way
    if (cach && !mis && !err_rgn && !hit)
    begin
      way                 = m_lru[a.idx];
      m_tag[a.idx][way]   = a.tag;
      m_valid[a.idx][way] = 1'b1;
      m_lru[a.idx]        = ~way;
    end
  endtask

  // request with flush for one cycle, must be dropped
  task automatic run_flush(input logic [ADR_W-1:0] adr, input logic cach);
    @(posedge clk);
    #DRV_DLY;
    fetch_req     = 1'b1;
    fetch_adr.raw = adr;
    cacheable     = cach;
    flush         = 1'b1;
    invalidate    = 1'b0;
    touch(adr);
    @(negedge clk);
    if (parcel_valid || parcel_error || mem_req.req)
    begin
      ctrl_errs++;
      $display("flushed fetch at %h was not dropped", adr);
    end
    @(posedge clk);
    #DRV_DLY;
    fetch_req = 1'b0;
    flush     = 1'b0;
  endtask

  task automatic run_invalidate();
    int cyc;
    @(posedge clk);
    #DRV_DLY;
    fetch_req  = 1'b0;
    flush      = 1'b0;
    invalidate = 1'b1;
    @(negedge clk);
    if (!stall)
    begin
      ctrl_errs++;
      $display("stall stayed low while an invalidate was pending");
    end
    @(posedge clk);
    #DRV_DLY;
    invalidate = 1'b0;
    cyc        = 0;
    do
    begin
      @(negedge clk);
      cyc++;
    end
    while (stall && cyc < FETCH_LIMIT);
    if (stall)
    begin
      ctrl_errs++;
      $display("invalidate did not complete within %0d cycles", FETCH_LIMIT);
    end
    for (int s = 0; s < SETS; s++)
      for (int w = 0; w < WAYS; w++)
        m_valid[s][w] = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int               pick;
    logic [ADR_W-1:0] adr;
    logic             cach;
    seed          = 32'hee0e_e0ce;
    parcel_errs   = 0;
    bus_errs      = 0;
    ctrl_errs     = 0;
    rst_n         = 1'b0;
    fetch_req     = 1'b0;
    fetch_adr.raw = '0;
    cacheable     = 1'b0;
    flush         = 1'b0;
    invalidate    = 1'b0;
    for (int s = 0; s < SETS; s++)
    begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < WAYS; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end

    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    if (stall || mem_req.req || parcel_valid || parcel_error)
    begin
      ctrl_errs++;
      $display("outputs active in the first cycle after reset");
    end

    for (int n = 0; n < N_FETCH; n++)
    begin
      pick = $unsigned($random(seed)) % 100;
      adr  = ($unsigned($random(seed)) % 64) * 4;
      cach = ($unsigned($random(seed)) % 4) != 0;
      // two lines at the error base
      if (pick >= 7 && pick < 13)
        adr = ERR_BASE + (adr & 32'h1c);
      if (pick >= 95)
        adr[1:0] = 2'(1 + pick % 3);
      if (pick < 3)
        run_invalidate();
      else if (pick < 7)
        run_flush(adr, cach);
      else
        run_fetch(adr, cach);
    end

    $display("errors: parcel %0d, bus %0d, control %0d", parcel_errs, bus_errs, ctrl_errs);
    if (parcel_errs + bus_errs + ctrl_errs == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // watchdog, 40 cycles per fetch plus reset
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all fetches finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_store.sv
src/line_refill.sv
src/fetch_bus_arb.sv
src/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  # rtl, package first
  - src/icache_pkg.sv
  - src/icache_ctrl.sv
  - src/icache_store.sv
  - src/line_refill.sv
  - src/fetch_bus_arb.sv
  - src/icache_top.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_icache.sv
